// ==== logic/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

    // Instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Datapath selectors
    typedef logic [2:0] alu_op_t;
    typedef logic [1:0] alu_src_b_t;
    typedef logic [2:0] pc_src_t;
    typedef logic [2:0] reg_dst_t;
    typedef logic [3:0] mem_to_reg_t;
    typedef logic [2:0] shift_op_t;
    typedef logic [1:0] branch_op_t;

    localparam alu_op_t ALU_PASS = 3'b000;
    localparam alu_op_t ALU_ADD  = 3'b001;
    localparam alu_op_t ALU_SUB  = 3'b010;
    localparam alu_op_t ALU_AND  = 3'b011;
    localparam alu_op_t ALU_CMP  = 3'b111;

    localparam alu_src_b_t SRC_B_REG   = 2'b00;
    localparam alu_src_b_t SRC_B_FOUR  = 2'b01;
    localparam alu_src_b_t SRC_B_IMM   = 2'b10;
    localparam alu_src_b_t SRC_B_SHOFF = 2'b11;  // Sign-extended offset << 2

    localparam pc_src_t PC_SRC_ALU    = 3'b000;
    localparam pc_src_t PC_SRC_ALUOUT = 3'b001;
    localparam pc_src_t PC_SRC_JUMP   = 3'b010;
    localparam pc_src_t PC_SRC_MDR    = 3'b110;  // Exception vector

    localparam reg_dst_t REG_DST_RT = 3'b000;
    localparam reg_dst_t REG_DST_RA = 3'b010;
    localparam reg_dst_t REG_DST_RD = 3'b011;

    localparam mem_to_reg_t WB_ALUOUT = 4'b0000;
    localparam mem_to_reg_t WB_SHIFT  = 4'b0100;
    localparam mem_to_reg_t WB_LT     = 4'b1000;

    localparam shift_op_t SHIFT_NONE = 3'b000;
    localparam shift_op_t SHIFT_LOAD = 3'b001;
    localparam shift_op_t SHIFT_LEFT = 3'b010;
    localparam shift_op_t SHIFT_SRL  = 3'b011;
    localparam shift_op_t SHIFT_SRA  = 3'b100;

    localparam branch_op_t BR_EQ = 2'b00;
    localparam branch_op_t BR_NE = 2'b01;
    localparam branch_op_t BR_GT = 2'b10;
    localparam branch_op_t BR_LE = 2'b11;

    typedef enum logic [3:0] {
        CLS_ALU_REG, CLS_ALU_IMM, CLS_SET_LESS, CLS_SHIFT_IMM, CLS_SHIFT_VAR,
        CLS_BRANCH, CLS_JUMP, CLS_JUMP_LINK, CLS_JUMP_REG, CLS_ILLEGAL
    } instr_class_e;

    // ST_TRAP4 must stay last
    typedef enum logic [4:0] {
        ST_FETCH1, ST_FETCH2, ST_DECODE1, ST_DECODE2, ST_DECODE3,
        ST_ALU_EXEC, ST_WRITE_BACK, ST_SET_LESS,
        ST_SHIFT_LOAD, ST_SHIFT_OP, ST_SHIFT_SAVE,
        ST_BRANCH, ST_JUMP, ST_JAL1, ST_JAL2, ST_JR1, ST_JR2,
        ST_ILLEGAL_OP, ST_TRAP1, ST_TRAP_WAIT, ST_TRAP3, ST_TRAP4
    } ctrl_state_e;

    typedef struct packed {
        opcode_t opcode;
        funct_t  funct;
    } instr_fields_t;

    typedef struct packed {
        instr_class_e cls;
        alu_op_t      alu_op;
        alu_src_b_t   alu_src_b;
        shift_op_t    shift_op;   // Direction only
        logic         shift_src;  // 1 = shamt field, 0 = rs
        branch_op_t   branch_op;
    } op_desc_t;

    typedef struct packed {
        logic        mem_read;
        logic        iord_pc;
        logic        ir_load;
        logic        ab_load;
        logic        aluout_load;
        logic        reg_write;
        logic        epc_load;
        logic        mdr_load;
        logic        pc_write;
        logic        pc_write_cond;
        logic        shift_src;
        logic        alu_src_a;   // 0 = PC, 1 = A register
        alu_op_t     alu_op;
        alu_src_b_t  alu_src_b;
        pc_src_t     pc_source;
        reg_dst_t    reg_dst;
        mem_to_reg_t mem_to_reg;
        shift_op_t   shift_op;
        branch_op_t  branch_op;
    } ctrl_word_t;

    localparam opcode_t OP_R     = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_BLE   = 6'h06;
    localparam opcode_t OP_BGT   = 6'h07;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;

    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRAV = 6'h07;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_SLT  = 6'h2a;

endpackage

// ==== logic/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder
    import cpu_ctrl_pkg::*;
(
    input  instr_fields_t instr,
    output op_desc_t      desc
);

    always_comb begin
        desc     = '0;
        desc.cls = CLS_ILLEGAL;
        case (instr.opcode)
            OP_R: begin
                case (instr.funct)
                    FN_ADD: begin
                        desc.cls    = CLS_ALU_REG;
                        desc.alu_op = ALU_ADD;
                    end
                    FN_SUB: begin
                        desc.cls    = CLS_ALU_REG;
                        desc.alu_op = ALU_SUB;
                    end
                    FN_AND: begin
                        desc.cls    = CLS_ALU_REG;
                        desc.alu_op = ALU_AND;
                    end
                    FN_SLT: begin
                        desc.cls    = CLS_SET_LESS;
                        desc.alu_op = ALU_CMP;
                    end
                    FN_JR: desc.cls = CLS_JUMP_REG;
                    // Immediate shifts take the amount from shamt
                    FN_SLL, FN_SRL, FN_SRA: begin
                        desc.cls       = CLS_SHIFT_IMM;
                        desc.shift_src = 1'b1;
                        desc.shift_op  = (instr.funct == FN_SLL) ? SHIFT_LEFT :
                                         (instr.funct == FN_SRL) ? SHIFT_SRL : SHIFT_SRA;
                    end
                    FN_SLLV, FN_SRAV: begin
                        desc.cls      = CLS_SHIFT_VAR;
                        desc.shift_op = (instr.funct == FN_SLLV) ? SHIFT_LEFT : SHIFT_SRA;
                    end
                    default: ;
                endcase
            end
            OP_ADDI, OP_ADDIU: begin  // No overflow trap, so both alike
                desc.cls       = CLS_ALU_IMM;
                desc.alu_op    = ALU_ADD;
                desc.alu_src_b = SRC_B_IMM;
            end
            OP_SLTI: begin
                desc.cls       = CLS_SET_LESS;
                desc.alu_op    = ALU_CMP;
                desc.alu_src_b = SRC_B_IMM;
            end
            OP_BEQ, OP_BNE, OP_BGT, OP_BLE: begin
                desc.cls       = CLS_BRANCH;
                desc.alu_op    = ALU_CMP;
                desc.branch_op = (instr.opcode == OP_BEQ) ? BR_EQ :
                                 (instr.opcode == OP_BNE) ? BR_NE :
                                 (instr.opcode == OP_BGT) ? BR_GT : BR_LE;
            end
            OP_J:    desc.cls = CLS_JUMP;
            OP_JAL:  desc.cls = CLS_JUMP_LINK;
            default: ;
        endcase
    end

    always_comb begin
        if (!$isunknown(instr)) begin
            assert (!$isunknown(desc.cls))
                else $error("instr_decoder: unknown class for opcode %h funct %h",
                            instr.opcode, instr.funct);
        end
    end

endmodule

// ==== logic/ctrl_sequencer.sv ====
`timescale 1ns/100ps

module ctrl_sequencer
    import cpu_ctrl_pkg::*;
#(
    parameter int MEM_LATENCY = 1
) (
    input  logic        clk,
    input  logic        arst_n,
    input  op_desc_t    desc,
    output ctrl_state_e state,
    output op_desc_t    desc_q
);

    localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(MEM_LATENCY - 1);

    ctrl_state_e      state_nxt;
    logic [CNT_W-1:0] wait_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_FETCH1;
        end else begin
            state <= state_nxt;
        end
    end

    // Counts trap_wait cycles, restarts on every trap
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
        end else if (state == ST_TRAP_WAIT) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // Operation held for the execute steps
    always_ff @(posedge clk) begin
        if (state == ST_DECODE3) begin
            desc_q <= desc;
        end
    end

    always_comb begin
        state_nxt = ST_FETCH1;
        case (state)
            ST_FETCH1:  state_nxt = ST_FETCH2;
            ST_FETCH2:  state_nxt = ST_DECODE1;
            ST_DECODE1: state_nxt = ST_DECODE2;
            ST_DECODE2: state_nxt = ST_DECODE3;
            ST_DECODE3: begin
                case (desc.cls)
                    CLS_ALU_REG, CLS_ALU_IMM:     state_nxt = ST_ALU_EXEC;
                    CLS_SET_LESS:                 state_nxt = ST_SET_LESS;
                    CLS_SHIFT_IMM, CLS_SHIFT_VAR: state_nxt = ST_SHIFT_LOAD;
                    CLS_BRANCH:                   state_nxt = ST_BRANCH;
                    CLS_JUMP:                     state_nxt = ST_JUMP;
                    CLS_JUMP_LINK:                state_nxt = ST_JAL1;
                    CLS_JUMP_REG:                 state_nxt = ST_JR1;
                    default:                      state_nxt = ST_ILLEGAL_OP;
                endcase
            end
            ST_ALU_EXEC:   state_nxt = ST_WRITE_BACK;
            ST_SHIFT_LOAD: state_nxt = ST_SHIFT_OP;
            ST_SHIFT_OP:   state_nxt = ST_SHIFT_SAVE;
            ST_JAL1:       state_nxt = ST_JAL2;
            ST_JAL2:       state_nxt = ST_JUMP;  // Link first, then jump
            ST_JR1:        state_nxt = ST_JR2;
            ST_ILLEGAL_OP: state_nxt = ST_TRAP1;
            ST_TRAP1:      state_nxt = ST_TRAP_WAIT;
            ST_TRAP_WAIT:  state_nxt = (wait_cnt == WAIT_LAST) ? ST_TRAP3 : ST_TRAP_WAIT;
            ST_TRAP3:      state_nxt = ST_TRAP4;
            default:       state_nxt = ST_FETCH1;  // Last step of every sequence
        endcase
    end

    // Enum is dense up to ST_TRAP4
    state_legal: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(state) && (state <= ST_TRAP4)
    ) else $error("ctrl_sequencer: state %0d outside enum", state);

    trap_wait_len: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == ST_TRAP1) |=> (state == ST_TRAP_WAIT) [*MEM_LATENCY] ##1 (state == ST_TRAP3)
    ) else $error("ctrl_sequencer: trap wait not %0d cycles", MEM_LATENCY);

endmodule

// ==== logic/ctrl_encoder.sv ====
`timescale 1ns/100ps

module ctrl_encoder
    import cpu_ctrl_pkg::*;
(
    input  ctrl_state_e state,
    input  op_desc_t    desc_q,
    output ctrl_word_t  ctrl
);

    always_comb begin
        ctrl = '0;
        case (state)
            ST_FETCH1: begin
                ctrl.mem_read = 1'b1;
                ctrl.iord_pc  = 1'b1;
            end
            ST_FETCH2: begin  // PC + 4
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PC_SRC_ALU;
                ctrl.alu_op    = ALU_ADD;
                ctrl.alu_src_b = SRC_B_FOUR;
            end
            ST_DECODE1: ctrl.ir_load = 1'b1;
            ST_DECODE2: ctrl.ab_load = 1'b1;
            ST_DECODE3: begin
                // Branch target ahead of time
                ctrl.aluout_load = 1'b1;
                ctrl.alu_op      = ALU_ADD;
                ctrl.alu_src_b   = SRC_B_SHOFF;
            end
            ST_ALU_EXEC: begin
                ctrl.alu_src_a   = 1'b1;
                ctrl.alu_op      = desc_q.alu_op;
                ctrl.alu_src_b   = desc_q.alu_src_b;
                ctrl.aluout_load = 1'b1;
            end
            ST_WRITE_BACK: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = WB_ALUOUT;
                ctrl.reg_dst    = (desc_q.cls == CLS_ALU_REG) ? REG_DST_RD : REG_DST_RT;
            end
            ST_SET_LESS: begin
                ctrl.alu_src_a  = 1'b1;
                ctrl.alu_op     = ALU_CMP;
                ctrl.alu_src_b  = desc_q.alu_src_b;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = WB_LT;
                // slti compares with the immediate and writes rt
                ctrl.reg_dst    = (desc_q.alu_src_b == SRC_B_REG) ? REG_DST_RD : REG_DST_RT;
            end
            ST_SHIFT_LOAD: begin
                ctrl.shift_op  = SHIFT_LOAD;
                ctrl.shift_src = desc_q.shift_src;
            end
            ST_SHIFT_OP: begin
                ctrl.shift_op  = desc_q.shift_op;
                ctrl.shift_src = desc_q.shift_src;
            end
            ST_SHIFT_SAVE: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = WB_SHIFT;
                ctrl.reg_dst    = REG_DST_RD;
            end
            ST_BRANCH: begin
                ctrl.pc_write_cond = 1'b1;
                ctrl.alu_src_a     = 1'b1;  // rs against rt
                ctrl.alu_op        = ALU_CMP;
                ctrl.pc_source     = PC_SRC_ALUOUT;
                ctrl.branch_op     = desc_q.branch_op;
            end
            ST_JUMP: begin
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PC_SRC_JUMP;
            end
            ST_JAL1: begin  // Return address is the already advanced PC
                ctrl.aluout_load = 1'b1;
                ctrl.alu_op      = ALU_PASS;
            end
            ST_JAL2: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = REG_DST_RA;
                ctrl.mem_to_reg = WB_ALUOUT;
            end
            ST_JR1: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.alu_op    = ALU_PASS;
            end
            ST_JR2: begin
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PC_SRC_ALU;
            end
            ST_ILLEGAL_OP: begin  // EPC = PC - 4
                ctrl.epc_load  = 1'b1;
                ctrl.alu_op    = ALU_SUB;
                ctrl.alu_src_b = SRC_B_FOUR;
            end
            ST_TRAP1:  ctrl.mem_read = 1'b1;  // Vector address, not PC
            ST_TRAP3:  ctrl.mdr_load = 1'b1;
            ST_TRAP4: begin
                ctrl.pc_write  = 1'b1;
                ctrl.pc_source = PC_SRC_MDR;
            end
            default: ;
        endcase
    end

    always_comb begin
        assert (!(ctrl.pc_write && ctrl.pc_write_cond))
            else $error("ctrl_encoder: pc_write and pc_write_cond both high in %s",
                        state.name());
    end

endmodule

// ==== logic/control_unit.sv ====
`timescale 1ns/100ps

module control_unit
    import cpu_ctrl_pkg::*;
#(
    parameter int MEM_LATENCY = 1
) (
    input  logic          clk,
    input  logic          arst_n,
    input  instr_fields_t instr,
    output ctrl_word_t    ctrl
);

    op_desc_t    desc;
    op_desc_t    desc_q;
    ctrl_state_e state;

    instr_decoder instr_decoder_i (
        .instr (instr),
        .desc  (desc)
    );

    ctrl_sequencer #(
        .MEM_LATENCY (MEM_LATENCY)
    ) ctrl_sequencer_i (
        .clk    (clk),
        .arst_n (arst_n),
        .desc   (desc),
        .state  (state),
        .desc_q (desc_q)
    );

    ctrl_encoder ctrl_encoder_i (
        .state  (state),
        .desc_q (desc_q),
        .ctrl   (ctrl)
    );

endmodule

// ==== dv/tb_ctrl_model.svh ====
`ifndef TB_CTRL_MODEL_SVH
`define TB_CTRL_MODEL_SVH

// Expected behavior of the control unit, per instruction class

function automatic ctrl_word_t fetch1_word();
    ctrl_word_t w;
    w          = '0;
    w.mem_read = 1'b1;
    w.iord_pc  = 1'b1;
    return w;
endfunction

function automatic int expected_cycles(instr_class_e cls);
    case (cls)
        CLS_ALU_REG, CLS_ALU_IMM, CLS_JUMP_REG: return 7;
        CLS_SET_LESS, CLS_BRANCH, CLS_JUMP:     return 6;
        CLS_SHIFT_IMM, CLS_SHIFT_VAR:           return 8;
        CLS_JUMP_LINK:                          return 8;
        default:                                return 9 + MEM_LATENCY;
    endcase
endfunction

// Writes to the PC after fetch2
function automatic int expected_late_pc_writes(instr_class_e cls);
    case (cls)
        CLS_JUMP, CLS_JUMP_LINK, CLS_JUMP_REG, CLS_ILLEGAL: return 1;
        default:                                            return 0;
    endcase
endfunction

function automatic instr_class_e expected_class(instr_fields_t f);
    instr_class_e c;
    c = CLS_ILLEGAL;
    case (f.opcode)
        OP_R: begin
            case (f.funct)
                FN_ADD, FN_SUB, FN_AND:  c = CLS_ALU_REG;
                FN_SLT:                  c = CLS_SET_LESS;
                FN_SLL, FN_SRL, FN_SRA:  c = CLS_SHIFT_IMM;
                FN_SLLV, FN_SRAV:        c = CLS_SHIFT_VAR;
                FN_JR:                   c = CLS_JUMP_REG;
                default:                 c = CLS_ILLEGAL;
            endcase
        end
        OP_ADDI, OP_ADDIU:               c = CLS_ALU_IMM;
        OP_SLTI:                         c = CLS_SET_LESS;
        OP_BEQ, OP_BNE, OP_BGT, OP_BLE:  c = CLS_BRANCH;
        OP_J:                            c = CLS_JUMP;
        OP_JAL:                          c = CLS_JUMP_LINK;
        default:                         c = CLS_ILLEGAL;
    endcase
    return c;
endfunction

function automatic alu_op_t expected_alu_op(instr_fields_t f);
    if (f.opcode == OP_R) begin
        return (f.funct == FN_SUB) ? ALU_SUB :
               (f.funct == FN_AND) ? ALU_AND :
               (f.funct == FN_SLT) ? ALU_CMP : ALU_ADD;
    end
    return (f.opcode == OP_SLTI) ? ALU_CMP : ALU_ADD;
endfunction

// R-type writes rd, immediate forms write rt
function automatic reg_dst_t expected_reg_dst(instr_fields_t f);
    return (f.opcode == OP_R) ? REG_DST_RD : REG_DST_RT;
endfunction

function automatic mem_to_reg_t expected_wb_src(instr_class_e cls);
    return (cls == CLS_SET_LESS) ? WB_LT : WB_ALUOUT;
endfunction

function automatic branch_op_t expected_branch_op(opcode_t op);
    return (op == OP_BEQ) ? BR_EQ :
           (op == OP_BNE) ? BR_NE :
           (op == OP_BGT) ? BR_GT : BR_LE;
endfunction

function automatic shift_op_t expected_shift_dir(funct_t fn);
    return (fn == FN_SLL || fn == FN_SLLV) ? SHIFT_LEFT :
           (fn == FN_SRL)                  ? SHIFT_SRL : SHIFT_SRA;
endfunction

`endif

// ==== dv/tb_control_unit.sv ====
`timescale 1ns/100ps

module tb_control_unit
    import cpu_ctrl_pkg::*;
;

    localparam int MEM_LATENCY  = 1;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ENTRIES  = 43;  // 23 fixed, 20 random
    localparam int WATCHDOG_NS  = NUM_ENTRIES * (10 + MEM_LATENCY) * 100 * 2
                                  + RESET_CYCLES * 100;

    typedef struct packed {
        instr_fields_t instr;
        instr_class_e  cls;
    } stim_t;

    `include "tb_ctrl_model.svh"

    logic          clk;
    logic          arst_n;
    instr_fields_t instr;
    ctrl_word_t    ctrl;

    string test_name [NUM_ENTRIES];
    stim_t stim      [NUM_ENTRIES];
    int    n_entries;

    control_unit #(
        .MEM_LATENCY (MEM_LATENCY)
    ) control_unit_i (
        .clk    (clk),
        .arst_n (arst_n),
        .instr  (instr),
        .ctrl   (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog: simulation hung, no end of test after %0d ns", WATCHDOG_NS);
        fail_run();
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_eq(input string name, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("CHECK FAILED %s %s: expected %0h actual %0h", name, what, exp, act);
            fail_run();
        end
    endtask

    task automatic add_entry(input string name, input opcode_t op, input funct_t fn,
                             input instr_class_e cls);
        test_name[n_entries]              = name;
        stim[n_entries].instr.opcode      = op;
        stim[n_entries].instr.funct       = fn;
        stim[n_entries].cls               = cls;
        n_entries++;
    endtask

    // Starts a small delay after the rising edge of a fetch1 cycle, ends at the next one
    task automatic run_entry(input string name, input stim_t s);
        ctrl_word_t trace [32];
        int n;
        int writes;
        int conds;
        int epcs;
        int late_pcw;
        int wr_idx;
        int cond_idx;
        int jmp_idx;
        instr = s.instr;
        n = 0;
        writes = 0;
        conds = 0;
        epcs = 0;
        late_pcw = 0;
        wr_idx = 0;
        cond_idx = 0;
        jmp_idx = 0;
        do begin
            @(negedge clk);
            trace[n] = ctrl;
            n++;
            @(posedge clk);
            #1;
        end while (!(ctrl.mem_read && ctrl.iord_pc) && n < 32);

        check_eq(name, "fetch1 word", fetch1_word(), trace[0]);
        check_eq(name, "cycles", expected_cycles(s.cls), n);
        check_eq(name, "fetch2 pc_write", 32'd1, 32'(trace[1].pc_write));
        for (int i = 0; i < n; i++) begin
            if (trace[i].reg_write) begin
                writes++;
                wr_idx = i;
            end
            if (trace[i].pc_write_cond) begin
                conds++;
                cond_idx = i;
            end
            if (trace[i].epc_load) epcs++;
            if (trace[i].pc_write && i != 1) begin
                late_pcw++;
                jmp_idx = i;
            end
        end
        check_eq(name, "late pc_write count", expected_late_pc_writes(s.cls), late_pcw);

        case (s.cls)
            CLS_ALU_REG, CLS_ALU_IMM, CLS_SET_LESS: begin
                check_eq(name, "alu_op", 32'(expected_alu_op(s.instr)), 32'(trace[5].alu_op));
                check_eq(name, "reg_write count", 32'd1, writes);
                check_eq(name, "reg_dst", 32'(expected_reg_dst(s.instr)),
                         32'(trace[wr_idx].reg_dst));
                check_eq(name, "mem_to_reg", 32'(expected_wb_src(s.cls)),
                         32'(trace[wr_idx].mem_to_reg));
            end
            CLS_BRANCH: begin
                check_eq(name, "pc_write_cond count", 32'd1, conds);
                check_eq(name, "branch_op", 32'(expected_branch_op(s.instr.opcode)),
                         32'(trace[cond_idx].branch_op));
            end
            CLS_SHIFT_IMM, CLS_SHIFT_VAR: begin
                check_eq(name, "shift load", 32'(SHIFT_LOAD), 32'(trace[5].shift_op));
                check_eq(name, "shift dir", 32'(expected_shift_dir(s.instr.funct)),
                         32'(trace[6].shift_op));
                check_eq(name, "load shift_src", 32'(s.cls == CLS_SHIFT_IMM),
                         32'(trace[5].shift_src));
                check_eq(name, "op shift_src", 32'(s.cls == CLS_SHIFT_IMM),
                         32'(trace[6].shift_src));
                check_eq(name, "reg_write count", 32'd1, writes);
            end
            CLS_JUMP_LINK: begin
                check_eq(name, "reg_write count", 32'd1, writes);
                check_eq(name, "link reg_dst", 32'(REG_DST_RA), 32'(trace[wr_idx].reg_dst));
                check_eq(name, "pc_source", 32'(PC_SRC_JUMP), 32'(trace[jmp_idx].pc_source));
                assert (wr_idx < jmp_idx) else begin
                    $display("%s: the ra write does not come before the jump cycle", name);
                    fail_run();
                end
            end
            CLS_JUMP, CLS_JUMP_REG: begin
                check_eq(name, "last pc_write", 32'd1, 32'(trace[n-1].pc_write));
                check_eq(name, "pc_source",
                         32'((s.cls == CLS_JUMP) ? PC_SRC_JUMP : PC_SRC_ALU),
                         32'(trace[n-1].pc_source));
            end
            default: begin  // Trap sequence
                check_eq(name, "epc_load count", 32'd1, epcs);
                check_eq(name, "reg_write count", 32'd0, writes);
                check_eq(name, "last pc_write", 32'd1, 32'(trace[n-1].pc_write));
                check_eq(name, "pc_source", 32'(PC_SRC_MDR), 32'(trace[n-1].pc_source));
            end
        endcase
    endtask

    initial begin
        logic [31:0]   rng;
        instr_fields_t f;
        arst_n    = 1'b0;
        instr     = '0;
        n_entries = 0;

        add_entry("add",   OP_R,     FN_ADD,  CLS_ALU_REG);
        add_entry("sub",   OP_R,     FN_SUB,  CLS_ALU_REG);
        add_entry("and",   OP_R,     FN_AND,  CLS_ALU_REG);
        add_entry("slt",   OP_R,     FN_SLT,  CLS_SET_LESS);
        add_entry("jr",    OP_R,     FN_JR,   CLS_JUMP_REG);
        add_entry("sll",   OP_R,     FN_SLL,  CLS_SHIFT_IMM);
        add_entry("srl",   OP_R,     FN_SRL,  CLS_SHIFT_IMM);
        add_entry("sra",   OP_R,     FN_SRA,  CLS_SHIFT_IMM);
        add_entry("sllv",  OP_R,     FN_SLLV, CLS_SHIFT_VAR);
        add_entry("srav",  OP_R,     FN_SRAV, CLS_SHIFT_VAR);
        add_entry("addi",  OP_ADDI,  6'h15,   CLS_ALU_IMM);
        add_entry("addiu", OP_ADDIU, 6'h2b,   CLS_ALU_IMM);
        add_entry("slti",  OP_SLTI,  6'h00,   CLS_SET_LESS);
        add_entry("beq",   OP_BEQ,   6'h00,   CLS_BRANCH);
        add_entry("bne",   OP_BNE,   6'h11,   CLS_BRANCH);
        add_entry("ble",   OP_BLE,   6'h22,   CLS_BRANCH);
        add_entry("bgt",   OP_BGT,   6'h33,   CLS_BRANCH);
        add_entry("j",     OP_J,     6'h3f,   CLS_JUMP);
        add_entry("jal",   OP_JAL,   6'h01,   CLS_JUMP_LINK);
        add_entry("ill_op3f",   6'h3f, 6'h00, CLS_ILLEGAL);
        add_entry("ill_lw",     6'h23, 6'h00, CLS_ILLEGAL);
        add_entry("ill_mult",   OP_R,  6'h18, CLS_ILLEGAL);
        add_entry("ill_mfhi",   OP_R,  6'h10, CLS_ILLEGAL);

        rng = 32'd7496;
        while (n_entries < NUM_ENTRIES) begin
            rng      = xorshift32(rng);
            f.opcode = rng[5:0];
            f.funct  = rng[13:8];
            add_entry($sformatf("rand_%0d_op%02h", n_entries, f.opcode),
                      f.opcode, f.funct, expected_class(f));
        end

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #1;
            check_eq("reset", "ctrl", fetch1_word(), ctrl);
        end
        arst_n = 1'b1;  // State stays fetch1 until the next edge

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(test_name[i], stim[i]);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+dv
logic/cpu_ctrl_pkg.sv
logic/instr_decoder.sv
logic/ctrl_sequencer.sv
logic/ctrl_encoder.sv
logic/control_unit.sv
dv/tb_control_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_control_unit -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
